/* source/emu_bus_pkg.sv */
`default_nettype none

package emu_bus_pkg;

    // Byte addresses seen on the two host ports
    typedef logic [11:0] csr_addr_t;
    typedef logic [11:0] mem_addr_t;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Default ideal memory depth in words
    localparam int MEM_DEPTH = 1024;

endpackage

`default_nettype wire

/* source/emu_regs_pkg.sv */
`default_nettype none

package emu_regs_pkg;

    typedef logic [63:0] cycle_t;

    // Control register map
    localparam emu_bus_pkg::csr_addr_t REG_EMU_CSR  = 12'h000;
    localparam emu_bus_pkg::csr_addr_t REG_CYCLE_LO = 12'h008;
    localparam emu_bus_pkg::csr_addr_t REG_CYCLE_HI = 12'h00C;

    // EMU_CSR fields
    localparam int CSR_HALT_BIT = 0;

endpackage

`default_nettype wire

/* source/reg_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface reg_bus_if #(
    parameter int ADDR_W = 12,
    parameter int DATA_W = 32
);

    logic                wen;
    logic [ADDR_W-1:0]   waddr;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic [ADDR_W-1:0]   raddr;
    logic [DATA_W-1:0]   rdata;

    modport initiator (
        output wen,
        output waddr,
        output wdata,
        output wstrb,
        output raddr,
        input  rdata
    );

    // Read data is combinational from raddr
    modport target (
        input  wen,
        input  waddr,
        input  wdata,
        input  wstrb,
        input  raddr,
        output rdata
    );

endinterface

`default_nettype wire

/* source/axilite_reg_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module axilite_reg_slave #(
    parameter int ADDR_W           = 12,
    parameter int DATA_W           = 32,
    parameter bit FULL_WORD_WRITES = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 awvalid,
    output logic                 awready,
    input  logic [ADDR_W-1:0]    awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  logic [DATA_W-1:0]    wdata,
    input  logic [DATA_W/8-1:0]  wstrb,
    output logic                 bvalid,
    input  logic                 bready,
    output emu_bus_pkg::resp_t   bresp,

    input  logic                 arvalid,
    output logic                 arready,
    input  logic [ADDR_W-1:0]    araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output logic [DATA_W-1:0]    rdata,
    output emu_bus_pkg::resp_t   rresp,

    reg_bus_if.initiator         bus
);

    import emu_bus_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_COMMIT,
        WR_RESP
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_RESP
    } rd_state_t;

    wr_state_t           wr_state;
    rd_state_t           rd_state;
    logic                aw_held;
    logic                w_held;
    logic                wr_err;
    logic [ADDR_W-1:0]   wr_addr;
    logic [DATA_W-1:0]   wr_data;
    logic [DATA_W/8-1:0] wr_strb;
    logic [ADDR_W-1:0]   rd_addr;
    logic [DATA_W-1:0]   rd_data;

    // Channels stay closed while a response waits
    assign awready = !aw_held && (wr_state != WR_RESP);
    assign wready  = !w_held && (wr_state != WR_RESP);
    assign bvalid  = (wr_state == WR_RESP);
    assign bresp   = wr_err ? RESP_SLVERR : RESP_OKAY;

    assign arready = (rd_state == RD_IDLE);
    assign rvalid  = (rd_state == RD_RESP);
    assign rdata   = rd_data;
    assign rresp   = RESP_OKAY;

    assign bus.wen   = (wr_state == WR_COMMIT) && !wr_err;
    assign bus.waddr = wr_addr;
    assign bus.wdata = wr_data;
    assign bus.wstrb = wr_strb;
    assign bus.raddr = rd_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= WR_IDLE;
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            wr_err   <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
                wr_err <= FULL_WORD_WRITES && (wstrb != '1);
            end
            case (wr_state)
                WR_IDLE: begin
                    if (aw_held && w_held) begin
                        wr_state <= WR_COMMIT;
                    end
                end
                WR_COMMIT: begin
                    aw_held  <= 1'b0;
                    w_held   <= 1'b0;
                    wr_state <= WR_RESP;
                end
                WR_RESP: begin
                    if (bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (arvalid) begin
                        rd_state <= RD_FETCH;
                    end
                end
                RD_FETCH: rd_state <= RD_RESP;
                RD_RESP: begin
                    if (rready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr_addr <= awaddr;
        end
        if (wvalid && wready) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
        if (arvalid && arready) begin
            rd_addr <= araddr;
        end
        // Target data sampled one edge after the address
        if (rd_state == RD_FETCH) begin
            rd_data <= bus.rdata;
        end
    end

    wen_single_pulse: assert property (@(posedge clk) disable iff (rst)
        bus.wen |=> !bus.wen);

    bvalid_held: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

    rvalid_held: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* source/emu_csr_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module emu_csr_regs (
    input  logic       clk,
    input  logic       rst,
    reg_bus_if.target  bus
);

    import emu_bus_pkg::*;
    import emu_regs_pkg::*;

    localparam int WORD_W = $bits(word_t);

    logic   halt;
    cycle_t cycle;
    word_t  rd_word;
    logic   wr_csr;
    logic   wr_lo;
    logic   wr_hi;

    assign wr_csr = bus.wen && (bus.waddr == REG_EMU_CSR);
    assign wr_lo  = bus.wen && (bus.waddr == REG_CYCLE_LO);
    assign wr_hi  = bus.wen && (bus.waddr == REG_CYCLE_HI);

    always_ff @(posedge clk) begin
        if (rst) begin
            halt <= 1'b0;
        end else if (wr_csr && bus.wstrb[CSR_HALT_BIT/8]) begin
            halt <= bus.wdata[CSR_HALT_BIT];
        end
    end

    // Free running unless halted and host writable only when halted
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (!halt) begin
            cycle <= cycle + cycle_t'(1);
        end else begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (wr_lo && bus.wstrb[i]) begin
                    cycle[i*8 +: 8] <= bus.wdata[i*8 +: 8];
                end
                if (wr_hi && bus.wstrb[i]) begin
                    cycle[WORD_W + i*8 +: 8] <= bus.wdata[i*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (bus.raddr)
            REG_EMU_CSR:  rd_word[CSR_HALT_BIT] = halt;
            REG_CYCLE_LO: rd_word = cycle[WORD_W-1:0];
            REG_CYCLE_HI: rd_word = cycle[$bits(cycle_t)-1 -: WORD_W];
            default:      rd_word = '0;
        endcase
    end

    assign bus.rdata = rd_word;

    cycle_frozen_when_halted: assert property (@(posedge clk) disable iff (rst)
        halt && !bus.wen |=> cycle == $past(cycle));

endmodule

`default_nettype wire

/* source/ideal_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module ideal_mem #(
    parameter int DEPTH = emu_bus_pkg::MEM_DEPTH
) (
    input  logic                    clk,
    input  emu_bus_pkg::mem_addr_t  fetch_addr,
    output emu_bus_pkg::word_t      fetch_data,
    input  emu_bus_pkg::mem_addr_t  data_addr,
    input  logic                    data_wen,
    input  emu_bus_pkg::word_t      data_wdata,
    input  emu_bus_pkg::strb_t      data_wstrb,
    output emu_bus_pkg::word_t      data_rdata,
    reg_bus_if.target               host
);

    import emu_bus_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);
    localparam int BYTES = $bits(strb_t);

    word_t            mem [DEPTH];
    logic [IDX_W-1:0] fetch_idx;
    logic [IDX_W-1:0] data_idx;
    logic [IDX_W-1:0] host_widx;
    logic [IDX_W-1:0] host_ridx;

    // Word index from the bits above the byte offset
    assign fetch_idx = fetch_addr[IDX_W+1:2];
    assign data_idx  = data_addr[IDX_W+1:2];
    assign host_widx = host.waddr[IDX_W+1:2];
    assign host_ridx = host.raddr[IDX_W+1:2];

    // Host write lands last so it wins a same-byte collision
    always_ff @(posedge clk) begin
        for (int i = 0; i < BYTES; i++) begin
            if (data_wen && data_wstrb[i]) begin
                mem[data_idx][i*8 +: 8] <= data_wdata[i*8 +: 8];
            end
        end
        for (int i = 0; i < BYTES; i++) begin
            if (host.wen && host.wstrb[i]) begin
                mem[host_widx][i*8 +: 8] <= host.wdata[i*8 +: 8];
            end
        end
    end

    assign fetch_data = mem[fetch_idx];
    assign data_rdata = mem[data_idx];
    assign host.rdata = mem[host_ridx];

    write_in_range: assert property (@(posedge clk)
        (!data_wen || int'(data_addr >> 2) < DEPTH) &&
        (!host.wen || int'(host.waddr >> 2) < DEPTH));

endmodule

`default_nettype wire

/* source/emu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module emu_top #(
    parameter int MEM_DEPTH = emu_bus_pkg::MEM_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst,

    // Control register port
    input  logic                    csr_awvalid,
    output logic                    csr_awready,
    input  emu_bus_pkg::csr_addr_t  csr_awaddr,
    input  logic                    csr_wvalid,
    output logic                    csr_wready,
    input  emu_bus_pkg::word_t      csr_wdata,
    input  emu_bus_pkg::strb_t      csr_wstrb,
    output logic                    csr_bvalid,
    input  logic                    csr_bready,
    output emu_bus_pkg::resp_t      csr_bresp,
    input  logic                    csr_arvalid,
    output logic                    csr_arready,
    input  emu_bus_pkg::csr_addr_t  csr_araddr,
    output logic                    csr_rvalid,
    input  logic                    csr_rready,
    output emu_bus_pkg::word_t      csr_rdata,
    output emu_bus_pkg::resp_t      csr_rresp,

    // Memory backdoor port
    input  logic                    mem_awvalid,
    output logic                    mem_awready,
    input  emu_bus_pkg::mem_addr_t  mem_awaddr,
    input  logic                    mem_wvalid,
    output logic                    mem_wready,
    input  emu_bus_pkg::word_t      mem_wdata,
    input  emu_bus_pkg::strb_t      mem_wstrb,
    output logic                    mem_bvalid,
    input  logic                    mem_bready,
    output emu_bus_pkg::resp_t      mem_bresp,
    input  logic                    mem_arvalid,
    output logic                    mem_arready,
    input  emu_bus_pkg::mem_addr_t  mem_araddr,
    output logic                    mem_rvalid,
    input  logic                    mem_rready,
    output emu_bus_pkg::word_t      mem_rdata,
    output emu_bus_pkg::resp_t      mem_rresp,

    // Core side
    input  emu_bus_pkg::mem_addr_t  fetch_addr,
    output emu_bus_pkg::word_t      fetch_data,
    input  emu_bus_pkg::mem_addr_t  data_addr,
    input  logic                    data_wen,
    input  emu_bus_pkg::word_t      data_wdata,
    input  emu_bus_pkg::strb_t      data_wstrb,
    output emu_bus_pkg::word_t      data_rdata
);

    import emu_bus_pkg::*;

    reg_bus_if #(.ADDR_W($bits(csr_addr_t)), .DATA_W($bits(word_t))) csr_bus ();
    reg_bus_if #(.ADDR_W($bits(mem_addr_t)), .DATA_W($bits(word_t))) mem_bus ();

    // Registers accept full-word writes only
    axilite_reg_slave #(
        .ADDR_W           ($bits(csr_addr_t)),
        .DATA_W           ($bits(word_t)),
        .FULL_WORD_WRITES (1'b1)
    ) u_csr_slave (
        .clk     (clk),
        .rst     (rst),
        .awvalid (csr_awvalid),
        .awready (csr_awready),
        .awaddr  (csr_awaddr),
        .wvalid  (csr_wvalid),
        .wready  (csr_wready),
        .wdata   (csr_wdata),
        .wstrb   (csr_wstrb),
        .bvalid  (csr_bvalid),
        .bready  (csr_bready),
        .bresp   (csr_bresp),
        .arvalid (csr_arvalid),
        .arready (csr_arready),
        .araddr  (csr_araddr),
        .rvalid  (csr_rvalid),
        .rready  (csr_rready),
        .rdata   (csr_rdata),
        .rresp   (csr_rresp),
        .bus     (csr_bus.initiator)
    );

    axilite_reg_slave #(
        .ADDR_W           ($bits(mem_addr_t)),
        .DATA_W           ($bits(word_t)),
        .FULL_WORD_WRITES (1'b0)
    ) u_mem_slave (
        .clk     (clk),
        .rst     (rst),
        .awvalid (mem_awvalid),
        .awready (mem_awready),
        .awaddr  (mem_awaddr),
        .wvalid  (mem_wvalid),
        .wready  (mem_wready),
        .wdata   (mem_wdata),
        .wstrb   (mem_wstrb),
        .bvalid  (mem_bvalid),
        .bready  (mem_bready),
        .bresp   (mem_bresp),
        .arvalid (mem_arvalid),
        .arready (mem_arready),
        .araddr  (mem_araddr),
        .rvalid  (mem_rvalid),
        .rready  (mem_rready),
        .rdata   (mem_rdata),
        .rresp   (mem_rresp),
        .bus     (mem_bus.initiator)
    );

    emu_csr_regs u_csr_regs (
        .clk (clk),
        .rst (rst),
        .bus (csr_bus.target)
    );

    ideal_mem #(
        .DEPTH (MEM_DEPTH)
    ) u_mem (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_addr  (data_addr),
        .data_wen   (data_wen),
        .data_wdata (data_wdata),
        .data_wstrb (data_wstrb),
        .data_rdata (data_rdata),
        .host       (mem_bus.target)
    );

endmodule

`default_nettype wire

/* dv/axilite_host.svh */
`ifndef AXILITE_HOST_SVH
`define AXILITE_HOST_SVH

// Ready level for the next cycle is random while back-pressure is on
function automatic logic pick_ready();
    return stall_en ? 1'($urandom_range(1)) : 1'b1;
endfunction

// One write on port p; with clash set the core stores to data_addr on the same edge
task automatic host_write(input logic p, input logic [11:0] addr, input word_t data,
                          input strb_t strb, input logic clash, output resp_t resp);
    logic aw_done;
    logic w_done;
    logic held;
    logic done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    held    = 1'b0;
    done    = 1'b0;
    resp    = RESP_OKAY;
    awvalid[p] <= 1'b1;
    awaddr[p]  <= addr;
    wvalid[p]  <= 1'b1;
    wdata[p]   <= data;
    wstrb[p]   <= strb;
    while (!(aw_done && w_done)) begin
        @(posedge clk);
        if (!aw_done && awready[p]) begin
            aw_done = 1'b1;
            awvalid[p] <= 1'b0;
        end
        if (!w_done && wready[p]) begin
            w_done = 1'b1;
            wvalid[p] <= 1'b0;
        end
    end
    bready[p] <= pick_ready();
    if (clash) begin
        // wen pulses in the cycle after both channels are held
        @(posedge clk);
        data_wen <= 1'b1;
    end
    while (!done) begin
        @(posedge clk);
        if (clash) begin
            data_wen <= 1'b0;
        end
        if (held) begin
            check(word_t'({bvalid[p], bresp[p]}), word_t'({1'b1, resp}), "write response held");
        end
        if (bvalid[p]) begin
            check(word_t'({awready[p], wready[p]}), 32'h0, "write channels closed");
            resp = bresp[p];
            held = 1'b1;
            done = bready[p];
        end
        bready[p] <= done ? 1'b0 : pick_ready();
    end
endtask

task automatic host_read(input logic p, input logic [11:0] addr,
                         output word_t data, output resp_t resp);
    logic held;
    logic done;
    held = 1'b0;
    done = 1'b0;
    data = '0;
    resp = RESP_OKAY;
    arvalid[p] <= 1'b1;
    araddr[p]  <= addr;
    @(posedge clk);
    while (!arready[p]) begin
        @(posedge clk);
    end
    arvalid[p] <= 1'b0;
    rready[p]  <= pick_ready();
    while (!done) begin
        @(posedge clk);
        if (held) begin
            check(rdata[p], data, "read data held");
            check(word_t'({rvalid[p], rresp[p]}), word_t'({1'b1, resp}), "read response held");
        end
        if (rvalid[p]) begin
            check(word_t'(arready[p]), 32'h0, "read address closed");
            data = rdata[p];
            resp = rresp[p];
            held = 1'b1;
            done = rready[p];
        end
        rready[p] <= done ? 1'b0 : pick_ready();
    end
endtask

`endif

/* dv/emu_top_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module emu_top_tb;

    import emu_bus_pkg::*;
    import emu_regs_pkg::*;

    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_CORE  = 2'd2;
    localparam logic [1:0] OP_CLASH = 2'd3;

    localparam word_t LO_VAL     = 32'h8000_0000;
    localparam word_t HI_VAL     = 32'h0000_00A5;
    localparam int    FILL_WORDS = 32;

    // port 0 is the CSR slave, port 1 the memory slave
    typedef struct packed {
        logic        port;
        logic [1:0]  op;
        logic        stall;
        logic [11:0] addr;
        word_t       data;
        strb_t       strb;
        word_t       exp_data;
        resp_t       exp_resp;
    } entry_t;

    logic             clk;
    logic             rst;
    logic [1:0]       awvalid;
    logic [1:0][11:0] awaddr;
    logic [1:0]       wvalid;
    logic [1:0][31:0] wdata;
    logic [1:0][3:0]  wstrb;
    logic [1:0]       bready;
    logic [1:0]       arvalid;
    logic [1:0][11:0] araddr;
    logic [1:0]       rready;
    wire  [1:0]       awready;
    wire  [1:0]       wready;
    wire  [1:0]       bvalid;
    wire  [1:0][1:0]  bresp;
    wire  [1:0]       arready;
    wire  [1:0]       rvalid;
    wire  [1:0][31:0] rdata;
    wire  [1:0][1:0]  rresp;
    logic [11:0]      fetch_addr;
    wire  [31:0]      fetch_data;
    logic [11:0]      data_addr;
    logic             data_wen;
    logic [31:0]      data_wdata;
    logic [3:0]       data_wstrb;
    wire  [31:0]      data_rdata;

    logic             stall_en;
    int               wd_cycles = 0;
    word_t            ref_mem [MEM_DEPTH];
    entry_t           table_q [$];

    emu_top #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .csr_awvalid (awvalid[0]),
        .csr_awready (awready[0]),
        .csr_awaddr  (awaddr[0]),
        .csr_wvalid  (wvalid[0]),
        .csr_wready  (wready[0]),
        .csr_wdata   (wdata[0]),
        .csr_wstrb   (wstrb[0]),
        .csr_bvalid  (bvalid[0]),
        .csr_bready  (bready[0]),
        .csr_bresp   (bresp[0]),
        .csr_arvalid (arvalid[0]),
        .csr_arready (arready[0]),
        .csr_araddr  (araddr[0]),
        .csr_rvalid  (rvalid[0]),
        .csr_rready  (rready[0]),
        .csr_rdata   (rdata[0]),
        .csr_rresp   (rresp[0]),
        .mem_awvalid (awvalid[1]),
        .mem_awready (awready[1]),
        .mem_awaddr  (awaddr[1]),
        .mem_wvalid  (wvalid[1]),
        .mem_wready  (wready[1]),
        .mem_wdata   (wdata[1]),
        .mem_wstrb   (wstrb[1]),
        .mem_bvalid  (bvalid[1]),
        .mem_bready  (bready[1]),
        .mem_bresp   (bresp[1]),
        .mem_arvalid (arvalid[1]),
        .mem_arready (arready[1]),
        .mem_araddr  (araddr[1]),
        .mem_rvalid  (rvalid[1]),
        .mem_rready  (rready[1]),
        .mem_rdata   (rdata[1]),
        .mem_rresp   (rresp[1]),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .data_addr   (data_addr),
        .data_wen    (data_wen),
        .data_wdata  (data_wdata),
        .data_wstrb  (data_wstrb),
        .data_rdata  (data_rdata)
    );

    task automatic check(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    `include "axilite_host.svh"

    function automatic word_t merge_bytes(input word_t old, input word_t nw, input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = nw[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic add_entry(input logic port, input logic [1:0] op, input logic [11:0] addr,
                             input word_t data, input strb_t strb, input word_t exp_data,
                             input resp_t exp_resp, input logic stall);
        table_q.push_back({port, op, stall, addr, data, strb, exp_data, exp_resp});
    endtask

    // Memory entry with its expected value from the reference model
    task automatic add_mem(input logic [1:0] op, input logic [11:0] addr, input word_t data,
                           input strb_t strb, input logic stall);
        word_t      exp;
        logic [9:0] idx;
        idx = addr[11:2];
        exp = '0;
        case (op)
            OP_READ:  exp = ref_mem[idx];
            OP_CLASH: ref_mem[idx] = merge_bytes(~data, data, strb);
            default:  ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
        endcase
        add_entry(1'b1, op, addr, data, strb, exp, RESP_OKAY, stall);
    endtask

    task automatic build_table();
        logic [11:0] addr;
        word_t       data;
        add_entry(1'b0, OP_WRITE, REG_EMU_CSR, 32'h1, 4'hF, '0, RESP_OKAY, 1'b0);
        add_entry(1'b0, OP_READ, REG_EMU_CSR, '0, '0, 32'h1, RESP_OKAY, 1'b0);
        add_entry(1'b0, OP_WRITE, REG_CYCLE_LO, LO_VAL, 4'hF, '0, RESP_OKAY, 1'b0);
        add_entry(1'b0, OP_WRITE, REG_CYCLE_HI, HI_VAL, 4'hF, '0, RESP_OKAY, 1'b0);
        add_entry(1'b0, OP_READ, REG_CYCLE_LO, '0, '0, LO_VAL, RESP_OKAY, 1'b0);
        add_entry(1'b0, OP_READ, REG_CYCLE_LO, '0, '0, LO_VAL, RESP_OKAY, 1'b0);
        add_entry(1'b0, OP_READ, REG_CYCLE_HI, '0, '0, HI_VAL, RESP_OKAY, 1'b0);
        add_entry(1'b0, OP_WRITE, REG_CYCLE_LO, 32'h1234_5678, 4'b0011, '0, RESP_SLVERR, 1'b0);
        add_entry(1'b0, OP_READ, REG_CYCLE_LO, '0, '0, LO_VAL, RESP_OKAY, 1'b0);
        add_entry(1'b0, OP_READ, 12'h010, '0, '0, '0, RESP_OKAY, 1'b0);
        add_entry(1'b0, OP_WRITE, REG_EMU_CSR, '0, 4'hF, '0, RESP_OKAY, 1'b0);
        // Known contents for the test region
        for (int w = 0; w < FILL_WORDS; w++) begin
            addr = 12'(w * 4);
            add_mem(OP_WRITE, addr, {4'hC, addr, 4'h3, addr}, 4'hF, 1'b0);
        end
        data = $urandom();
        add_mem(OP_WRITE, 12'h010, data, strb_t'($urandom_range(14, 1)), 1'b0);
        add_mem(OP_READ, 12'h010, '0, '0, 1'b0);
        add_mem(OP_CORE, 12'h020, 32'hDEAD_BEEF, 4'b0101, 1'b0);
        add_mem(OP_READ, 12'h020, '0, '0, 1'b0);
        add_mem(OP_CLASH, 12'h024, 32'h1122_3344, 4'b0110, 1'b0);
        add_mem(OP_READ, 12'h024, '0, '0, 1'b0);
        for (int n = 0; n < 64; n++) begin
            addr = 12'($urandom_range(FILL_WORDS - 1) * 4);
            if ($urandom_range(1) == 1) begin
                add_mem(OP_WRITE, addr, $urandom(), strb_t'($urandom_range(15)), 1'b1);
            end else begin
                add_mem(OP_READ, addr, '0, '0, 1'b1);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        entry_t e;
        word_t  rd;
        word_t  first;
        resp_t  resp;
        rst        = 1'b1;
        awvalid    = '0;
        awaddr     = '0;
        wvalid     = '0;
        wdata      = '0;
        wstrb      = '0;
        bready     = '0;
        arvalid    = '0;
        araddr     = '0;
        rready     = '0;
        fetch_addr = '0;
        data_addr  = '0;
        data_wen   = 1'b0;
        data_wdata = '0;
        data_wstrb = '0;
        stall_en   = 1'b0;
        void'($urandom(15996));
        build_table();
        wd_cycles = (table_q.size() + 8) * 200;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check(word_t'({awready, wready, arready}), 32'h3F, "ready after reset");
        check(word_t'({bvalid, rvalid}), 32'h0, "no response after reset");
        host_read(1'b0, REG_EMU_CSR, rd, resp);
        check(rd, 32'h0, "EMU_CSR after reset");
        host_read(1'b0, REG_CYCLE_LO, first, resp);
        check(word_t'(first != 32'h0), 32'h1, "counter running");
        host_read(1'b0, REG_CYCLE_LO, rd, resp);
        check(word_t'(rd > first), 32'h1, "counter rising");

        foreach (table_q[i]) begin
            e = table_q[i];
            stall_en = e.stall;
            case (e.op)
                OP_WRITE: begin
                    host_write(e.port, e.addr, e.data, e.strb, 1'b0, resp);
                    check(word_t'(resp), word_t'(e.exp_resp), $sformatf("entry %0d bresp", i));
                end
                OP_CLASH: begin
                    data_addr  <= e.addr;
                    data_wdata <= ~e.data;
                    data_wstrb <= 4'hF;
                    host_write(e.port, e.addr, e.data, e.strb, 1'b1, resp);
                    check(word_t'(resp), word_t'(e.exp_resp), $sformatf("entry %0d bresp", i));
                end
                OP_CORE: begin
                    data_addr  <= e.addr;
                    data_wdata <= e.data;
                    data_wstrb <= e.strb;
                    data_wen   <= 1'b1;
                    @(posedge clk);
                    data_wen   <= 1'b0;
                end
                default: begin
                    fetch_addr <= e.addr;
                    data_addr  <= e.addr;
                    host_read(e.port, e.addr, rd, resp);
                    check(rd, e.exp_data, $sformatf("entry %0d rdata", i));
                    check(word_t'(resp), word_t'(e.exp_resp), $sformatf("entry %0d rresp", i));
                    if (e.port) begin
                        check(data_rdata, e.exp_data, $sformatf("entry %0d data_rdata", i));
                        check(fetch_data, e.exp_data, $sformatf("entry %0d fetch_data", i));
                    end
                end
            endcase
        end

        // Counter resumed from the value written while halted
        stall_en = 1'b0;
        host_read(1'b0, REG_CYCLE_LO, rd, resp);
        check(word_t'(rd > LO_VAL), 32'h1, "counter resumed");
        host_read(1'b0, REG_CYCLE_HI, rd, resp);
        check(rd, HI_VAL, "counter high half");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+dv
source/emu_bus_pkg.sv
source/emu_regs_pkg.sv
source/reg_bus_if.sv
source/axilite_reg_slave.sv
source/emu_csr_regs.sv
source/ideal_mem.sv
source/emu_top.sv
dv/emu_top_tb.sv

/* Makefile */
# Verilator build and run of the emulation shell testbench

VERILATOR ?= verilator
TOP       ?= emu_top_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
